// ==== filelist.f ====
verilog/icache_pkg.sv
verilog/icache_set_store.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/icache_mem_model.sv
test/icache_asserts.sv
test/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/100ps \
	--top-module icache_tb -f filelist.f -o icache_sim

./obj_dir/icache_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"

// ==== test/icache_tb.sv ====
module icache_tb import icache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SET_BITS = 7;
	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_W = 64 - SET_BITS - OFFSET_W;
	localparam int NUM_FETCH = 600;
	localparam int TIMEOUT = NUM_FETCH * 60; // worst case miss plus gap per fetch
	localparam logic [31:0] SEED = 32'he64f2f50;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_BITS-1:0] set_t;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     cpu_req;
	addr_t    cpu_addr;
	logic     cpu_ack;
	word_t    cpu_data;
	logic     mem_req;
	mem_req_t mem_cmd;
	logic     mem_ack;
	word_t    mem_data;

	integer seed;
	int     cycles = 0;
	int     fetch_idx = 0;
	logic   mem_req_prev = 1'b0;
	addr_t  beat_addrs [$];
	beat_t  beat_nums [$];

	// reference model of valid, tag and lru per set
	logic [1:0] m_valid [SETS];
	logic       m_lru [SETS];
	tag_t       m_tag [SETS][2];
	tag_t       tag_pool [6];
	set_t       set_pool [4];

	icache_top #(
		.SET_BITS (SET_BITS)
	) DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpu_req  (cpu_req),
		.cpu_addr (cpu_addr),
		.cpu_ack  (cpu_ack),
		.cpu_data (cpu_data),
		.mem_req  (mem_req),
		.mem_cmd  (mem_cmd),
		.mem_ack  (mem_ack),
		.mem_data (mem_data)
	);

	icache_mem_model #(
		.SEED (SEED)
	) u_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_req  (mem_req),
		.mem_cmd  (mem_cmd),
		.mem_ack  (mem_ack),
		.mem_data (mem_data)
	);

	bind icache_top icache_asserts u_asserts (
		.clk     (clk),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.cpu_ack (cpu_ack),
		.mem_req (mem_req),
		.mem_ack (mem_ack),
		.mem_cmd (mem_cmd)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act) else fail_now($sformatf(
			"ERR %s expected %h actual %h (fetch %0d)", name, exp, act, fetch_idx));
	endtask

	// predicts hit or miss and applies the replacement rules
	function automatic logic model_access(input addr_t addr);
		set_t s;
		tag_t t;
		logic hit;
		logic way;
		s = addr[OFFSET_W +: SET_BITS];
		t = addr[63 -: TAG_W];
		hit = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[s][w] && m_tag[s][w] == t) begin
				hit = 1'b1;
				way = 1'(w);
			end
		end
		if (!hit) begin
			if (!m_valid[s][0]) way = 1'b0;
			else if (!m_valid[s][1]) way = 1'b1;
			else way = m_lru[s];
			m_valid[s][way] = 1'b1;
			m_tag[s][way] = t;
		end
		m_lru[s] = ~way; // away from the way just used
		return hit;
	endfunction

	function automatic addr_t pick_addr();
		logic [31:0] r;
		int          ti;
		r = $random(seed);
		ti = r[10:8] % 6;
		return {tag_pool[ti], set_pool[r[6:5]], r[4:0]};
	endfunction

	// memory beats seen during the current fetch
	always @(negedge clk) begin
		if (rst_n && mem_req && !mem_req_prev) begin
			beat_addrs.push_back(mem_cmd.addr);
			beat_nums.push_back(mem_cmd.beat);
		end
		mem_req_prev = mem_req;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			fail_now($sformatf("timeout after %0d cycles, fetch %0d did not complete",
				cycles, fetch_idx));
		end
	end

	task automatic run_fetch(input addr_t addr, input int hold);
		logic  exp_hit;
		word_t exp_data;
		addr_t line_addr;
		int    edges;
		int    beats;
		exp_hit = model_access(addr);
		exp_data = u_mem.scramble(addr);
		line_addr = {addr[63:OFFSET_W], {OFFSET_W{1'b0}}};
		beat_addrs.delete();
		beat_nums.delete();
		cpu_addr = addr;
		cpu_req = 1'b1;
		edges = 0;
		do begin
			@(negedge clk);
			edges++;
		end while (!cpu_ack);
		beats = beat_addrs.size();
		check_value("data", exp_data, cpu_data);
		check_value("hit", 64'(exp_hit), 64'(beats == 0));
		if (exp_hit) begin
			check_value("hit latency", 64'd3, 64'(edges - 1)); // edge 0 samples cpu_req
		end else begin
			check_value("beat count", 64'd4, 64'(beats));
			for (int b = 0; b < BEATS; b++) begin
				check_value("beat index", 64'(b), 64'(beat_nums[b]));
				check_value("beat addr", line_addr + 64'(b * 8), beat_addrs[b]);
			end
		end
		repeat (hold) begin
			@(negedge clk);
			assert (cpu_ack) else fail_now("cpu_ack dropped while cpu_req was still high");
			check_value("held data", exp_data, cpu_data);
		end
		cpu_req = 1'b0;
		@(negedge clk);
		assert (!cpu_ack) else fail_now("cpu_ack still high one cycle after cpu_req fell");
		check_value("late beats", 64'(beats), 64'(beat_addrs.size()));
	endtask

	initial begin
		logic [31:0] r;
		logic [63:0] r64;
		seed = SEED;
		rst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_addr = '0;
		for (int s = 0; s < SETS; s++) begin
			m_valid[s] = '0;
			m_lru[s] = 1'b0;
		end
		for (int i = 0; i < 6; i++) begin
			r64 = {$random(seed), $random(seed)};
			tag_pool[i] = r64[TAG_W-1:0];
		end
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			set_pool[i] = r[SET_BITS-1:0];
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		for (int i = 0; i < NUM_FETCH; i++) begin
			fetch_idx = i;
			r = $random(seed);
			run_fetch(pick_addr(), int'(r[1:0])); // hold cpu_req 0 to 3 extra cycles
			repeat (int'(r[3:2])) @(negedge clk);
		end
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== test/icache_asserts.sv ====
module icache_asserts import icache_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     cpu_req,
	input logic     cpu_ack,
	input logic     mem_req,
	input logic     mem_ack,
	input mem_req_t mem_cmd
);

	timeunit 1ns;
	timeprecision 100ps;

	// pending beat keeps its request and command
	property mem_cmd_held;
		@(posedge clk) disable iff (!rst_n)
			mem_req && !mem_ack |=> mem_req && $stable(mem_cmd);
	endproperty

	property cpu_ack_held;
		@(posedge clk) disable iff (!rst_n)
			cpu_ack && cpu_req |=> cpu_ack;
	endproperty

	property quiet_after_reset;
		@(posedge clk) !rst_n |=> !mem_req && !cpu_ack;
	endproperty

	a_mem_cmd_held: assert property (mem_cmd_held)
		else $error("mem_cmd or mem_req changed while a memory beat was pending");
	a_cpu_ack_held: assert property (cpu_ack_held)
		else $error("cpu_ack fell while cpu_req was still high");
	a_quiet_after_reset: assert property (quiet_after_reset)
		else $error("mem_req or cpu_ack high after reset");

endmodule

// ==== test/icache_mem_model.sv ====
module icache_mem_model import icache_pkg::*; #(
	parameter logic [31:0] SEED = 32'he64f2f50
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     mem_req,
	input  mem_req_t mem_cmd,
	output logic     mem_ack,
	output word_t    mem_data
);

	timeunit 1ns;
	timeprecision 100ps;

	integer seed;
	int     delay;

	// data word of a memory address, from the word address only
	function automatic word_t scramble(input addr_t addr);
		word_t w;
		w = {3'b000, addr[63:3]};
		w = w * 64'h9e37_79b9_7f4a_7c15; // odd multiplier, one word per address
		return w ^ {w[31:0], w[63:32]} ^ 64'h0123_4567_89ab_cdef;
	endfunction

	// four-phase responder, driven on the falling edge
	initial begin
		seed = SEED;
		mem_ack = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge clk);
			if (rst_n && mem_req && !mem_ack) begin
				delay = $unsigned($random(seed)) % 4; // 0 to 3 cycles
				repeat (delay) @(negedge clk);
				mem_data = scramble(mem_cmd.addr);
				mem_ack = 1'b1;
				while (mem_req) begin
					@(negedge clk);
				end
				mem_ack = 1'b0;
				mem_data = '0; // data only valid with ack
			end
		end
	end

endmodule

// ==== verilog/icache_top.sv ====
module icache_top import icache_pkg::*; #(
	parameter int SET_BITS = 7
) (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     cpu_req,
	input  addr_t    cpu_addr,
	output logic     cpu_ack,
	output word_t    cpu_data,

	output logic     mem_req,
	output mem_req_t mem_cmd,
	input  logic     mem_ack,
	input  word_t    mem_data
);

	logic    lookup_en;
	addr_t   lookup_addr;
	lookup_t lookup;
	logic    victim;
	logic    refill_start;
	addr_t   refill_addr;
	logic    refill_way;
	logic    refill_done;
	fill_t   fill;

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_req      (cpu_req),
		.cpu_addr     (cpu_addr),
		.cpu_ack      (cpu_ack),
		.cpu_data     (cpu_data),
		.lookup_en    (lookup_en),
		.lookup_addr  (lookup_addr),
		.lookup       (lookup),
		.victim       (victim),
		.refill_start (refill_start),
		.refill_addr  (refill_addr),
		.refill_way   (refill_way),
		.refill_done  (refill_done)
	);

	icache_set_store #(
		.SET_BITS (SET_BITS)
	) u_store (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_en   (lookup_en),
		.lookup_addr (lookup_addr),
		.lookup      (lookup),
		.victim      (victim),
		.fill        (fill)
	);

	icache_refill #(
		.SET_BITS (SET_BITS)
	) u_refill (
		.clk          (clk),
		.rst_n        (rst_n),
		.refill_start (refill_start),
		.refill_addr  (refill_addr),
		.refill_way   (refill_way),
		.refill_done  (refill_done),
		.mem_req      (mem_req),
		.mem_cmd      (mem_cmd),
		.mem_ack      (mem_ack),
		.mem_data     (mem_data),
		.fill         (fill)
	);

endmodule

// ==== verilog/icache_ctrl.sv ====
module icache_ctrl import icache_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,

	// fetch side
	input  logic    cpu_req,
	input  addr_t   cpu_addr,
	output logic    cpu_ack,
	output word_t   cpu_data,

	// set store
	output logic    lookup_en,
	output addr_t   lookup_addr,
	input  lookup_t lookup,
	input  logic    victim,

	// refill unit
	output logic    refill_start,
	output addr_t   refill_addr,
	output logic    refill_way,
	input  logic    refill_done
);

	typedef enum logic [2:0] {IDLE, LOOKUP, COMPARE, REFILL, ACK} state_t;

	state_t state;
	logic   rsp_valid; // lookup result registered in the store
	addr_t  addr_q;
	logic   way_q;
	beat_t  word_sel;
	word_t  hit_word;

	assign lookup_addr = addr_q;
	assign refill_addr = {addr_q[63:OFFSET_W], {OFFSET_W{1'b0}}};
	assign refill_way = way_q;

	assign word_sel = addr_q[4:3];
	assign hit_word = lookup.line[word_sel*64 +: 64];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			lookup_en <= 1'b0;
			rsp_valid <= 1'b0;
			refill_start <= 1'b0;
			cpu_ack <= 1'b0;
		end else begin
			lookup_en <= 1'b0;
			refill_start <= 1'b0;
			rsp_valid <= lookup_en;

			case (state)
				IDLE: if (cpu_req) begin
					state <= LOOKUP;
				end
				LOOKUP: begin
					lookup_en <= 1'b1; // address latched this edge
					state <= COMPARE;
				end
				COMPARE: if (rsp_valid) begin
					if (lookup.hit) begin
						cpu_ack <= 1'b1;
						state <= ACK;
					end else begin
						refill_start <= 1'b1;
						state <= REFILL;
					end
				end
				REFILL: if (refill_done) begin
					lookup_en <= 1'b1; // second lookup, line now present
					state <= COMPARE;
				end
				ACK: if (!cpu_req) begin
					cpu_ack <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOOKUP) begin
			addr_q <= cpu_addr;
		end
		if (state == COMPARE && rsp_valid) begin
			if (lookup.hit) begin
				cpu_data <= hit_word; // held through ACK
			end else begin
				way_q <= victim;
			end
		end
	end

endmodule

// ==== verilog/icache_refill.sv ====
module icache_refill import icache_pkg::*; #(
	parameter int SET_BITS = 7
) (
	input  logic     clk,
	input  logic     rst_n,

	input  logic     refill_start,
	input  addr_t    refill_addr,
	input  logic     refill_way,
	output logic     refill_done,

	output logic     mem_req,
	output mem_req_t mem_cmd,
	input  logic     mem_ack,
	input  word_t    mem_data,

	output fill_t    fill
);

	localparam int TAG_W = 64 - SET_BITS - OFFSET_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_BITS-1:0] set_t;
	typedef enum logic [1:0] {IDLE, REQ, RELEASE, WRITE} state_t;

	state_t state;
	tag_t   tag_q;
	set_t   set_q;
	logic   way_q;
	beat_t  beat_q;
	line_t  line_q;

	assign mem_cmd.addr = {tag_q, set_q, beat_q, 3'b000};
	assign mem_cmd.beat = beat_q;

	// write strobe and done share the WRITE cycle
	assign refill_done = (state == WRITE);
	assign fill.valid = (state == WRITE);
	assign fill.way = way_q;
	assign fill.addr = {tag_q, set_q, {OFFSET_W{1'b0}}};
	assign fill.line = line_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			mem_req <= 1'b0;
			beat_q <= '0;
		end else begin
			case (state)
				IDLE: if (refill_start) begin
					beat_q <= '0;
					mem_req <= 1'b1;
					state <= REQ;
				end
				REQ: if (mem_ack) begin
					mem_req <= 1'b0; // data captured below
					state <= RELEASE;
				end
				RELEASE: if (!mem_ack) begin
					if (beat_q == beat_t'(BEATS - 1)) begin
						state <= WRITE;
					end else begin
						beat_q <= beat_q + 1'b1;
						mem_req <= 1'b1;
						state <= REQ;
					end
				end
				WRITE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && refill_start) begin
			{tag_q, set_q} <= refill_addr[63:OFFSET_W];
			way_q <= refill_way;
		end
		if (state == REQ && mem_ack) begin
			line_q <= {mem_data, line_q[BEATS*64-1:64]}; // beat 0 ends lowest
		end
	end

endmodule

// ==== verilog/icache_set_store.sv ====
module icache_set_store import icache_pkg::*; #(
	parameter int SET_BITS = 7
) (
	input  logic    clk,
	input  logic    rst_n,

	input  logic    lookup_en,
	input  addr_t   lookup_addr,
	output lookup_t lookup,
	output logic    victim,

	input  fill_t   fill
);

	localparam int SETS = 1 << SET_BITS;
	localparam int TAG_W = 64 - SET_BITS - OFFSET_W;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_BITS-1:0] set_t;

	logic [1:0] valid_q [SETS]; // one bit per way
	logic       lru_q [SETS];   // way to replace next
	tag_t       tag_q [2][SETS];
	line_t      data_q [2][SETS];

	set_t       rd_set;
	tag_t       rd_tag;
	set_t       wr_set;
	tag_t       wr_tag;
	logic [1:0] way_hit;
	logic       victim_d;

	assign rd_set = lookup_addr[OFFSET_W +: SET_BITS];
	assign rd_tag = lookup_addr[63 -: TAG_W];
	assign wr_set = fill.addr[OFFSET_W +: SET_BITS];
	assign wr_tag = fill.addr[63 -: TAG_W];

	// tag compare on both ways
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[rd_set][w] && (tag_q[w][rd_set] == rd_tag);
		end
	end

	// invalid way first, way 0 before way 1
	always_comb begin
		if (!valid_q[rd_set][0]) begin
			victim_d = 1'b0;
		end else if (!valid_q[rd_set][1]) begin
			victim_d = 1'b1;
		end else begin
			victim_d = lru_q[rd_set];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				lru_q[s] <= 1'b0;
			end
		end else begin
			if (lookup_en && |way_hit) begin
				lru_q[rd_set] <= ~way_hit[1]; // point away from the hit
			end
			if (fill.valid) begin
				valid_q[wr_set][fill.way] <= 1'b1;
				lru_q[wr_set] <= ~fill.way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill.valid) begin
			tag_q[fill.way][wr_set] <= wr_tag;
			data_q[fill.way][wr_set] <= fill.line;
		end
	end

	// registered lookup result
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			lookup.hit <= |way_hit;
			lookup.hit_way <= way_hit[1];
			lookup.line <= data_q[way_hit[1]][rd_set];
			victim <= victim_d;
		end
	end

endmodule

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

	typedef logic [63:0] addr_t;
	typedef logic [63:0] word_t;

	// line geometry
	localparam int OFFSET_W = 5;
	localparam int BEATS = 4;

	typedef logic [BEATS*64-1:0] line_t;
	typedef logic [1:0] beat_t; // word within a line

	// refill unit to set store
	typedef struct packed {
		logic  valid; // one cycle write strobe
		logic  way;
		addr_t addr;  // line address
		line_t line;
	} fill_t;

	// set store to controller
	typedef struct packed {
		logic  hit;
		logic  hit_way;
		line_t line;
	} lookup_t;

	// memory side command
	typedef struct packed {
		addr_t addr; // word aligned
		beat_t beat;
	} mem_req_t;

endpackage
